// ==== rtl/cpu_pkg.sv ====
// cpu types, opcode encodings and ALU function codes for the five-stage core
package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [15:0] pc_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [3:0]  opcode_t;
    typedef logic [2:0]  alu_op_t;

    // opcodes, instruction bits 15:12
    localparam opcode_t OP_NOP  = 4'd0;
    localparam opcode_t OP_ADD  = 4'd1;
    localparam opcode_t OP_SUB  = 4'd2;
    localparam opcode_t OP_AND  = 4'd3;
    localparam opcode_t OP_OR   = 4'd4;
    localparam opcode_t OP_XOR  = 4'd5;
    localparam opcode_t OP_SLL  = 4'd6;
    localparam opcode_t OP_SRL  = 4'd7;
    localparam opcode_t OP_ADDI = 4'd8;
    localparam opcode_t OP_LD   = 4'd9;
    localparam opcode_t OP_ST   = 4'd10;
    localparam opcode_t OP_BEQZ = 4'd11;
    localparam opcode_t OP_BNEZ = 4'd12;
    // 13 and 14 are not assigned
    localparam opcode_t OP_HALT = 4'd15;

    // alu functions
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLL = 3'd5;
    localparam alu_op_t ALU_SRL = 3'd6;

endpackage

// ==== rtl/pipe_if.sv ====
// pipeline register bundles between decode, execute, memory and writeback
`timescale 1ns/100ps

interface id_ex_if;
    logic                valid;
    cpu_pkg::alu_op_t    alu_op;
    cpu_pkg::reg_idx_t   rd, rs, rt;
    cpu_pkg::word_t      rs_val, rt_val, imm;
    // pc of the instruction plus one, base for branch targets
    cpu_pkg::pc_t        pc1;
    logic                use_imm;
    logic                is_load, is_store;
    logic                is_beqz, is_bnez;
    logic                rf_wen, halt, illegal;

    modport source (
        output valid, alu_op, rd, rs, rt, rs_val, rt_val, imm, pc1,
        output use_imm, is_load, is_store, is_beqz, is_bnez, rf_wen, halt, illegal
    );
    modport sink (
        input valid, alu_op, rd, rs, rt, rs_val, rt_val, imm, pc1,
        input use_imm, is_load, is_store, is_beqz, is_bnez, rf_wen, halt, illegal
    );
endinterface

interface ex_mem_if;
    logic                valid;
    cpu_pkg::word_t      alu_out, store_data;
    cpu_pkg::reg_idx_t   rd;
    logic                rf_wen, is_load, is_store;
    logic                halt, illegal;

    modport source (
        output valid, alu_out, store_data, rd, rf_wen, is_load, is_store, halt, illegal
    );
    modport sink (
        input valid, alu_out, store_data, rd, rf_wen, is_load, is_store, halt, illegal
    );
endinterface

interface mem_wb_if;
    logic                valid;
    cpu_pkg::word_t      alu_out, load_data;
    cpu_pkg::reg_idx_t   rd;
    logic                rf_wen, is_load;
    logic                halt, illegal;

    modport source (
        output valid, alu_out, load_data, rd, rf_wen, is_load, halt, illegal
    );
    modport sink (
        input valid, alu_out, load_data, rd, rf_wen, is_load, halt, illegal
    );
endinterface

// ==== rtl/fetch.sv ====
// fetch stage: program counter with stall freeze and branch redirect, IF/ID register
`timescale 1ns/100ps

module fetch (
    input  logic            i_clk,
    input  logic            i_arst_n,
    input  logic            i_stall,
    input  logic            i_redirect,
    input  cpu_pkg::pc_t    i_redirect_pc,
    input  cpu_pkg::word_t  i_instr,
    output cpu_pkg::pc_t    o_pc,
    output cpu_pkg::word_t  o_instr,
    output logic            o_instr_valid
);

    // redirect beats stall, the instruction fetched alongside it is dropped
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc          <= '0;
            o_instr_valid <= 1'b0;
        end else if (i_redirect) begin
            o_pc          <= i_redirect_pc;
            o_instr_valid <= 1'b0;
        end else if (!i_stall) begin
            o_pc          <= o_pc + 16'd1;
            o_instr_valid <= 1'b1;
        end
    end

    // instruction word is only meaningful with o_instr_valid
    always_ff @(posedge i_clk) begin
        if (!i_stall && !i_redirect) begin
            o_instr <= i_instr;
        end
    end

endmodule

// ==== rtl/decode.sv ====
// decode stage: field split, register file with bypass, load-use and halt stall, ID/EX register
`timescale 1ns/100ps

module decode (
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  cpu_pkg::word_t     i_instr,
    input  logic               i_instr_valid,
    // fetch pc runs one ahead of the decoded instruction
    input  cpu_pkg::pc_t       i_pc1,
    input  logic               i_redirect,
    input  logic               i_wb_wen,
    input  cpu_pkg::reg_idx_t  i_wb_rd,
    input  cpu_pkg::word_t     i_wb_data,
    output logic               o_stall,
    id_ex_if.source            o_id_ex
);

    cpu_pkg::word_t     regs [8];
    cpu_pkg::opcode_t   op;
    cpu_pkg::reg_idx_t  f_rd, f_rs, f_rt, rt_sel;
    cpu_pkg::word_t     imm, rs_val, rt_val;
    cpu_pkg::alu_op_t   alu_op;
    logic               use_imm, is_load, is_store, is_beqz, is_bnez;
    logic               rf_wen, is_halt, illegal, reads_rt;
    logic               load_use, halted, issue;

    assign op   = i_instr[15:12];
    assign f_rd = i_instr[11:9];
    assign f_rs = i_instr[8:6];
    assign f_rt = i_instr[5:3];
    assign imm  = {{10{i_instr[5]}}, i_instr[5:0]};

    // stores carry rd as their data operand on the rt path
    assign rt_sel = is_store ? f_rd : f_rt;

    always_comb begin
        use_imm  = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        is_beqz  = 1'b0;
        is_bnez  = 1'b0;
        rf_wen   = 1'b0;
        is_halt  = 1'b0;
        illegal  = 1'b0;
        reads_rt = 1'b0;
        case (op)
            cpu_pkg::OP_NOP: begin
            end
            cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
            cpu_pkg::OP_XOR, cpu_pkg::OP_SLL, cpu_pkg::OP_SRL: begin
                rf_wen   = 1'b1;
                reads_rt = 1'b1;
            end
            cpu_pkg::OP_ADDI: begin
                rf_wen  = 1'b1;
                use_imm = 1'b1;
            end
            cpu_pkg::OP_LD: begin
                rf_wen  = 1'b1;
                use_imm = 1'b1;
                is_load = 1'b1;
            end
            cpu_pkg::OP_ST: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            cpu_pkg::OP_BEQZ: is_beqz = 1'b1;
            cpu_pkg::OP_BNEZ: is_bnez = 1'b1;
            cpu_pkg::OP_HALT: is_halt = 1'b1;
            // unassigned opcodes go down the pipe as a flagged no-op
            default: illegal = 1'b1;
        endcase
    end

    always_comb begin
        case (op)
            cpu_pkg::OP_SUB: alu_op = cpu_pkg::ALU_SUB;
            cpu_pkg::OP_AND: alu_op = cpu_pkg::ALU_AND;
            cpu_pkg::OP_OR:  alu_op = cpu_pkg::ALU_OR;
            cpu_pkg::OP_XOR: alu_op = cpu_pkg::ALU_XOR;
            cpu_pkg::OP_SLL: alu_op = cpu_pkg::ALU_SLL;
            cpu_pkg::OP_SRL: alu_op = cpu_pkg::ALU_SRL;
            default:         alu_op = cpu_pkg::ALU_ADD;
        endcase
    end

    // register file, r0 is never written
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb_wen && i_wb_rd != '0) begin
            regs[i_wb_rd] <= i_wb_data;
        end
    end

    // same-cycle writeback is visible to the read
    function automatic cpu_pkg::word_t rf_read(cpu_pkg::reg_idx_t idx);
        cpu_pkg::word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (i_wb_wen && i_wb_rd == idx) begin
            val = i_wb_data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs_val = rf_read(f_rs);
        rt_val = rf_read(rt_sel);
    end

    // load in execute feeding this instruction, data not ready until writeback
    assign load_use = i_instr_valid && o_id_ex.valid && o_id_ex.is_load
                   && o_id_ex.rd != '0
                   && ((op != cpu_pkg::OP_NOP && f_rs == o_id_ex.rd)
                    || (reads_rt && f_rt == o_id_ex.rd)
                    || (is_store && f_rd == o_id_ex.rd));

    assign o_stall = load_use || halted;
    assign issue   = i_instr_valid && !o_stall && !i_redirect;

    // once halt is issued nothing younger follows it
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            halted <= 1'b0;
        end else if (issue && is_halt) begin
            halted <= 1'b1;
        end
    end

    // ID/EX control
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_id_ex.valid    <= 1'b0;
            o_id_ex.use_imm  <= 1'b0;
            o_id_ex.is_load  <= 1'b0;
            o_id_ex.is_store <= 1'b0;
            o_id_ex.is_beqz  <= 1'b0;
            o_id_ex.is_bnez  <= 1'b0;
            o_id_ex.rf_wen   <= 1'b0;
            o_id_ex.halt     <= 1'b0;
            o_id_ex.illegal  <= 1'b0;
        end else begin
            o_id_ex.valid    <= issue;
            o_id_ex.use_imm  <= use_imm;
            o_id_ex.is_load  <= is_load;
            o_id_ex.is_store <= is_store;
            o_id_ex.is_beqz  <= is_beqz;
            o_id_ex.is_bnez  <= is_bnez;
            o_id_ex.rf_wen   <= rf_wen;
            o_id_ex.halt     <= is_halt;
            o_id_ex.illegal  <= illegal;
        end
    end

    // ID/EX payload
    always_ff @(posedge i_clk) begin
        o_id_ex.alu_op <= alu_op;
        o_id_ex.rd     <= f_rd;
        o_id_ex.rs     <= f_rs;
        o_id_ex.rt     <= rt_sel;
        o_id_ex.rs_val <= rs_val;
        o_id_ex.rt_val <= rt_val;
        o_id_ex.imm    <= imm;
        o_id_ex.pc1    <= i_pc1;
    end

endmodule

// ==== rtl/execute.sv ====
// execute stage: operand forwarding, ALU, branch resolution and the EX/MEM register
`timescale 1ns/100ps

module execute (
    input  logic               i_clk,
    input  logic               i_arst_n,
    id_ex_if.sink              i_id_ex,
    ex_mem_if.source           o_ex_mem,
    input  logic               i_wb_wen,
    input  cpu_pkg::reg_idx_t  i_wb_rd,
    input  cpu_pkg::word_t     i_wb_data,
    output logic               o_redirect,
    output cpu_pkg::pc_t       o_redirect_pc
);

    cpu_pkg::word_t  rs_fwd, rt_fwd, alu_b, alu_out;

    // memory stage is younger than writeback, so it wins
    function automatic cpu_pkg::word_t fwd(cpu_pkg::reg_idx_t idx, cpu_pkg::word_t val);
        cpu_pkg::word_t res;
        if (o_ex_mem.valid && o_ex_mem.rf_wen && o_ex_mem.rd != '0 && o_ex_mem.rd == idx) begin
            res = o_ex_mem.alu_out;
        end else if (i_wb_wen && i_wb_rd != '0 && i_wb_rd == idx) begin
            res = i_wb_data;
        end else begin
            res = val;
        end
        return res;
    endfunction

    always_comb begin
        rs_fwd = fwd(i_id_ex.rs, i_id_ex.rs_val);
        rt_fwd = fwd(i_id_ex.rt, i_id_ex.rt_val);
    end

    assign alu_b = i_id_ex.use_imm ? i_id_ex.imm : rt_fwd;

    always_comb begin
        case (i_id_ex.alu_op)
            cpu_pkg::ALU_SUB: alu_out = rs_fwd - alu_b;
            cpu_pkg::ALU_AND: alu_out = rs_fwd & alu_b;
            cpu_pkg::ALU_OR:  alu_out = rs_fwd | alu_b;
            cpu_pkg::ALU_XOR: alu_out = rs_fwd ^ alu_b;
            // shift amount is the low nibble only
            cpu_pkg::ALU_SLL: alu_out = rs_fwd << alu_b[3:0];
            cpu_pkg::ALU_SRL: alu_out = rs_fwd >> alu_b[3:0];
            default:          alu_out = rs_fwd + alu_b;
        endcase
    end

    // taken branch, fetch and decode drop their instructions next edge
    assign o_redirect = i_id_ex.valid
                     && ((i_id_ex.is_beqz && rs_fwd == '0)
                      || (i_id_ex.is_bnez && rs_fwd != '0));
    assign o_redirect_pc = i_id_ex.pc1 + i_id_ex.imm;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ex_mem.valid    <= 1'b0;
            o_ex_mem.rf_wen   <= 1'b0;
            o_ex_mem.is_load  <= 1'b0;
            o_ex_mem.is_store <= 1'b0;
            o_ex_mem.halt     <= 1'b0;
            o_ex_mem.illegal  <= 1'b0;
        end else begin
            o_ex_mem.valid    <= i_id_ex.valid;
            o_ex_mem.rf_wen   <= i_id_ex.rf_wen;
            o_ex_mem.is_load  <= i_id_ex.is_load;
            o_ex_mem.is_store <= i_id_ex.is_store;
            o_ex_mem.halt     <= i_id_ex.halt;
            o_ex_mem.illegal  <= i_id_ex.illegal;
        end
    end

    always_ff @(posedge i_clk) begin
        o_ex_mem.alu_out    <= alu_out;
        o_ex_mem.store_data <= rt_fwd;
        o_ex_mem.rd         <= i_id_ex.rd;
    end

endmodule

// ==== rtl/memory.sv ====
// memory stage: data RAM access and the MEM/WB register
`timescale 1ns/100ps

module memory #(
    parameter int DMEM_ADDR_W = 6
) (
    input  logic      i_clk,
    input  logic      i_arst_n,
    ex_mem_if.sink    i_ex_mem,
    mem_wb_if.source  o_mem_wb
);

    localparam int DEPTH = 2 ** DMEM_ADDR_W;

    cpu_pkg::word_t          ram [DEPTH];
    logic [DMEM_ADDR_W-1:0]  addr;

    // addresses wrap over the RAM depth
    assign addr = i_ex_mem.alu_out[DMEM_ADDR_W-1:0];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                ram[i] <= '0;
            end
        end else if (i_ex_mem.valid && i_ex_mem.is_store) begin
            ram[addr] <= i_ex_mem.store_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_mem_wb.valid   <= 1'b0;
            o_mem_wb.rf_wen  <= 1'b0;
            o_mem_wb.is_load <= 1'b0;
            o_mem_wb.halt    <= 1'b0;
            o_mem_wb.illegal <= 1'b0;
        end else begin
            o_mem_wb.valid   <= i_ex_mem.valid;
            o_mem_wb.rf_wen  <= i_ex_mem.rf_wen;
            o_mem_wb.is_load <= i_ex_mem.is_load;
            o_mem_wb.halt    <= i_ex_mem.halt;
            o_mem_wb.illegal <= i_ex_mem.illegal;
        end
    end

    // combinational read, captured at the end of the stage
    always_ff @(posedge i_clk) begin
        o_mem_wb.alu_out   <= i_ex_mem.alu_out;
        o_mem_wb.load_data <= ram[addr];
        o_mem_wb.rd        <= i_ex_mem.rd;
    end

endmodule

// ==== rtl/writeback.sv ====
// writeback stage: result select, register write port and sticky halt and error flags
`timescale 1ns/100ps

module writeback (
    input  logic               i_clk,
    input  logic               i_arst_n,
    mem_wb_if.sink             i_mem_wb,
    output logic               o_wb_wen,
    output cpu_pkg::reg_idx_t  o_wb_rd,
    output cpu_pkg::word_t     o_wb_data,
    output logic               o_halt,
    output logic               o_err
);

    // writes to r0 are dropped here so they never count as retirements
    assign o_wb_wen  = i_mem_wb.valid && i_mem_wb.rf_wen && i_mem_wb.rd != '0;
    assign o_wb_rd   = i_mem_wb.rd;
    assign o_wb_data = i_mem_wb.is_load ? i_mem_wb.load_data : i_mem_wb.alu_out;

    // both flags hold until reset
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_halt <= 1'b0;
            o_err  <= 1'b0;
        end else begin
            if (i_mem_wb.valid && i_mem_wb.halt) begin
                o_halt <= 1'b1;
            end
            if (i_mem_wb.valid && i_mem_wb.illegal) begin
                o_err <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/proc.sv ====
// five-stage in-order 16-bit processor top, stages joined by pipeline bundles
`timescale 1ns/100ps

module proc #(
    parameter int DMEM_ADDR_W = 6
) (
    input  logic               i_clk,
    input  logic               i_arst_n,
    output cpu_pkg::pc_t       o_pc,
    input  cpu_pkg::word_t     i_instr,
    output logic               o_wb_valid,
    output cpu_pkg::reg_idx_t  o_wb_reg,
    output cpu_pkg::word_t     o_wb_data,
    output logic               o_halt,
    output logic               o_err
);

    cpu_pkg::word_t     instr;
    logic               instr_valid;
    logic               stall;
    logic               redirect;
    cpu_pkg::pc_t       redirect_pc;
    // writeback loopback to the register file and forwarding
    logic               wb_wen;
    cpu_pkg::reg_idx_t  wb_rd;
    cpu_pkg::word_t     wb_data;

    id_ex_if   u_id_ex ();
    ex_mem_if  u_ex_mem ();
    mem_wb_if  u_mem_wb ();

    fetch u_fetch (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_stall        (stall),
        .i_redirect     (redirect),
        .i_redirect_pc  (redirect_pc),
        .i_instr        (i_instr),
        .o_pc           (o_pc),
        .o_instr        (instr),
        .o_instr_valid  (instr_valid)
    );

    decode u_decode (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_instr        (instr),
        .i_instr_valid  (instr_valid),
        .i_pc1          (o_pc),
        .i_redirect     (redirect),
        .i_wb_wen       (wb_wen),
        .i_wb_rd        (wb_rd),
        .i_wb_data      (wb_data),
        .o_stall        (stall),
        .o_id_ex        (u_id_ex.source)
    );

    execute u_execute (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_id_ex        (u_id_ex.sink),
        .o_ex_mem       (u_ex_mem.source),
        .i_wb_wen       (wb_wen),
        .i_wb_rd        (wb_rd),
        .i_wb_data      (wb_data),
        .o_redirect     (redirect),
        .o_redirect_pc  (redirect_pc)
    );

    memory #(
        .DMEM_ADDR_W    (DMEM_ADDR_W)
    ) u_memory (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_ex_mem       (u_ex_mem.sink),
        .o_mem_wb       (u_mem_wb.source)
    );

    writeback u_writeback (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_mem_wb       (u_mem_wb.sink),
        .o_wb_wen       (wb_wen),
        .o_wb_rd        (wb_rd),
        .o_wb_data      (wb_data),
        .o_halt         (o_halt),
        .o_err          (o_err)
    );

    assign o_wb_valid = wb_wen;
    assign o_wb_reg   = wb_rd;
    assign o_wb_data  = wb_data;

endmodule

// ==== bench/isa_model.svh ====
// instruction-set model: runs a program in order and lists its register writes
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// expected writes in retirement order, r0 left out
cpu_pkg::reg_idx_t  exp_reg  [$];
cpu_pkg::word_t     exp_data [$];
logic               exp_err;

task automatic run_model();
    cpu_pkg::word_t     regs [8];
    cpu_pkg::word_t     dmem [2 ** DMEM_ADDR_W];
    cpu_pkg::word_t     instr, a, b, imm, ea, res;
    cpu_pkg::opcode_t   op;
    cpu_pkg::reg_idx_t  rd, rs, rt;
    logic               wr, done;
    int                 pc, steps;
    exp_reg.delete();
    exp_data.delete();
    exp_err = 1'b0;
    for (int i = 0; i < 8; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < 2 ** DMEM_ADDR_W; i++) begin
        dmem[i] = '0;
    end
    pc    = 0;
    steps = 0;
    done  = 1'b0;
    while (!done && steps < 4096) begin
        instr = fetch_word(pc);
        op    = instr[15:12];
        rd    = instr[11:9];
        rs    = instr[8:6];
        rt    = instr[5:3];
        imm   = {{10{instr[5]}}, instr[5:0]};
        a     = regs[rs];
        b     = regs[rt];
        ea    = a + imm;
        res   = '0;
        pc++;
        steps++;
        case (op)
            cpu_pkg::OP_ADD:  res = a + b;
            cpu_pkg::OP_SUB:  res = a - b;
            cpu_pkg::OP_AND:  res = a & b;
            cpu_pkg::OP_OR:   res = a | b;
            cpu_pkg::OP_XOR:  res = a ^ b;
            cpu_pkg::OP_SLL:  res = a << b[3:0];
            cpu_pkg::OP_SRL:  res = a >> b[3:0];
            cpu_pkg::OP_ADDI: res = ea;
            cpu_pkg::OP_LD:   res = dmem[ea[DMEM_ADDR_W-1:0]];
            cpu_pkg::OP_ST:   dmem[ea[DMEM_ADDR_W-1:0]] = regs[rd];
            // pc already points past the branch
            cpu_pkg::OP_BEQZ: if (a == '0) pc = pc + int'($signed(imm));
            cpu_pkg::OP_BNEZ: if (a != '0) pc = pc + int'($signed(imm));
            cpu_pkg::OP_HALT: done = 1'b1;
            cpu_pkg::OP_NOP: begin
            end
            default:          exp_err = 1'b1;
        endcase
        // register writers are opcodes ADD through LD
        wr = (op >= cpu_pkg::OP_ADD && op <= cpu_pkg::OP_LD);
        if (wr && rd != '0) begin
            regs[rd] = res;
            exp_reg.push_back(rd);
            exp_data.push_back(res);
        end
    end
endtask

`endif

// ==== bench/tb_proc.sv ====
// testbench for the five-stage core that checks random programs against an instruction-set model
`timescale 1ns/100ps

module tb_proc;

    localparam int DMEM_ADDR_W  = 6;
    localparam int PROG_LEN     = 48;
    localparam int NUM_PROGS    = 20;
    localparam int ERR_PROG     = 7;
    localparam int HALT_TIMEOUT = 2000;

    logic               i_clk;
    logic               i_arst_n;
    cpu_pkg::pc_t       o_pc;
    cpu_pkg::word_t     i_instr;
    logic               o_wb_valid;
    cpu_pkg::reg_idx_t  o_wb_reg;
    cpu_pkg::word_t     o_wb_data;
    logic               o_halt;
    logic               o_err;

    // random instructions followed by HALT
    cpu_pkg::word_t     prog [PROG_LEN + 1];
    int                 seed;
    int                 errors;
    int                 checks;

    proc #(
        .DMEM_ADDR_W  (DMEM_ADDR_W)
    ) u_proc (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .o_pc         (o_pc),
        .i_instr      (i_instr),
        .o_wb_valid   (o_wb_valid),
        .o_wb_reg     (o_wb_reg),
        .o_wb_data    (o_wb_data),
        .o_halt       (o_halt),
        .o_err        (o_err)
    );

    // NOP past the end of the program
    function automatic cpu_pkg::word_t fetch_word(int pc);
        cpu_pkg::word_t w;
        if (pc >= 0 && pc <= PROG_LEN) begin
            w = prog[pc];
        end else begin
            w = '0;
        end
        return w;
    endfunction

    `include "isa_model.svh"

    function automatic cpu_pkg::word_t encode(cpu_pkg::opcode_t op, cpu_pkg::reg_idx_t rd,
                                               cpu_pkg::reg_idx_t rs, logic [5:0] low);
        return {op, rd, rs, low};
    endfunction

    // dense programs stay on r1 to r3 for back-to-back hazards
    function automatic cpu_pkg::reg_idx_t pick_reg(logic dense);
        cpu_pkg::reg_idx_t r;
        if (dense) begin
            r = 3'(1 + {$random(seed)} % 3);
        end else begin
            r = 3'({$random(seed)} % 8);
        end
        return r;
    endfunction

    task automatic check_value(string name, int expected, int actual);
        checks++;
        assert (expected == actual) else begin
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_true(logic cond, string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic build_program(int num);
        int                 kind;
        int                 off;
        int                 i;
        logic               dense;
        cpu_pkg::reg_idx_t  rd;
        cpu_pkg::reg_idx_t  rs;
        logic [5:0]         low;
        logic [5:0]         addr;
        dense = (num % 2 == 0);
        i = 0;
        while (i < PROG_LEN) begin
            kind = {$random(seed)} % 16;
            rd   = pick_reg(dense);
            rs   = pick_reg(dense);
            low  = 6'($random(seed));
            // loads and stores use r0 as base, so addresses stay in 0..7
            addr = 6'({$random(seed)} % 8);
            if (kind < 7) begin
                prog[i] = encode(4'(kind + 1), rd, rs, {pick_reg(dense), 3'b000});
            end else if (kind == 9 || kind == 10) begin
                prog[i] = encode(cpu_pkg::OP_LD, rd, 3'd0, addr);
            end else if (kind == 11) begin
                prog[i] = encode(cpu_pkg::OP_ST, rd, 3'd0, addr);
                if (i < PROG_LEN - 1 && $random(seed) % 2 == 0) begin
                    i++;
                    prog[i] = encode(cpu_pkg::OP_LD, pick_reg(dense), 3'd0, addr);
                end
            end else if ((kind == 12 || kind == 13) && i < PROG_LEN - 1) begin
                // branches go forward only and never past the HALT
                off = 1 + {$random(seed)} % 4;
                if (off > PROG_LEN - 1 - i) begin
                    off = PROG_LEN - 1 - i;
                end
                prog[i] = encode(kind == 12 ? cpu_pkg::OP_BEQZ : cpu_pkg::OP_BNEZ,
                                 3'd0, rs, 6'(off));
            end else if (kind == 14) begin
                prog[i] = '0;
            end else begin
                prog[i] = encode(cpu_pkg::OP_ADDI, rd, kind == 15 ? rd : rs, low);
            end
            i++;
        end
        prog[PROG_LEN] = encode(cpu_pkg::OP_HALT, 3'd0, 3'd0, 6'd0);
        if (num == ERR_PROG) begin
            prog[0] = {4'd13, 12'($random(seed))};
        end
    endtask

    task automatic apply_reset(int num);
        @(negedge i_clk);
        i_arst_n = 1'b0;
        repeat (2) begin
            @(negedge i_clk);
            i_instr = fetch_word(int'(o_pc));
        end
        check_value($sformatf("prog %0d reset o_pc", num), 0, int'(o_pc));
        check_value($sformatf("prog %0d reset o_wb_valid", num), 0, int'(o_wb_valid));
        check_value($sformatf("prog %0d reset o_halt", num), 0, int'(o_halt));
        check_value($sformatf("prog %0d reset o_err", num), 0, int'(o_err));
        i_arst_n = 1'b1;
    endtask

    task automatic run_program(int num);
        int cycles;
        int ret;
        cycles = 0;
        ret    = 0;
        while (!o_halt && cycles < HALT_TIMEOUT) begin
            @(negedge i_clk);
            i_instr = fetch_word(int'(o_pc));
            cycles++;
            if (o_wb_valid) begin
                check_true(!o_halt, $sformatf("program %0d: retirement after halt", num));
                if (ret < exp_reg.size()) begin
                    check_value($sformatf("prog %0d write %0d reg", num, ret),
                                int'(exp_reg[ret]), int'(o_wb_reg));
                    check_value($sformatf("prog %0d write %0d data", num, ret),
                                int'(exp_data[ret]), int'(o_wb_data));
                end else begin
                    check_true(1'b0, $sformatf("program %0d: more retirements than expected",
                                               num));
                end
                ret++;
            end
        end
        check_true(o_halt, $sformatf("program %0d: o_halt did not rise within %0d cycles",
                                     num, HALT_TIMEOUT));
        check_value($sformatf("prog %0d retirement count", num), exp_reg.size(), ret);
        check_value($sformatf("prog %0d o_err at halt", num), int'(exp_err), int'(o_err));
        // the pipe stays quiet once halted and fetch stops two words past the HALT
        repeat (4) begin
            @(negedge i_clk);
            i_instr = fetch_word(int'(o_pc));
            check_true(!o_wb_valid, $sformatf("program %0d: retirement after halt", num));
            check_value($sformatf("prog %0d pc after halt", num), PROG_LEN + 2, int'(o_pc));
        end
    endtask

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    initial begin
        seed     = 32'h6aab_53ba;
        errors   = 0;
        checks   = 0;
        i_arst_n = 1'b0;
        i_instr  = '0;
        for (int n = 0; n < NUM_PROGS; n++) begin
            build_program(n);
            run_model();
            apply_reset(n);
            run_program(n);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+bench
rtl/cpu_pkg.sv
rtl/pipe_if.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execute.sv
rtl/memory.sv
rtl/writeback.sv
rtl/proc.sv
bench/tb_proc.sv

// ==== run.sh ====
#!/bin/sh
# build the core and its testbench with Verilator, run it, pass only on the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_proc -o tb_proc_sim
out=$(./obj_dir/tb_proc_sim)
echo "$out"
echo "$out" | grep -qx "Everything OK"
